/* design/mlpPkg.sv */
package mlpPkg;

	localparam int NUM_INPUTS = 15;
	localparam int NUM_HIDDEN = 8;
	localparam int NUM_CLASSES = 4;
	localparam int NEURON_LATENCY = 3; // input, sum and activation registers.

	typedef logic [15:0] activation_t;
	typedef logic [15:0] weight_t;
	typedef logic [1:0] classIndex_t;

	typedef weight_t [0:NUM_HIDDEN-1][0:NUM_INPUTS-1] hiddenWeights_t;
	typedef weight_t [0:NUM_CLASSES-1][0:NUM_HIDDEN-1] outputWeights_t;
	typedef activation_t [0:NUM_HIDDEN-1] hiddenBiases_t;
	typedef activation_t [0:NUM_CLASSES-1] outputBiases_t;

	typedef struct packed {
		logic valid;
		activation_t [NUM_INPUTS-1:0] activations;
	} sampleBus_t;

	typedef struct packed {
		logic valid;
		classIndex_t classIndex;
		activation_t score; // two's complement.
	} classResult_t;

	// every hidden row has a negative weight on input 5, so a large value there
	// pulls all hidden sums below zero.
	localparam hiddenWeights_t HIDDEN_WEIGHTS = '{
		'{-16'sd15, 16'sd4, 16'sd10, 16'sd60, 16'sd26, -16'sd25, 16'sd48, -16'sd28,
			16'sd6, 16'sd10, -16'sd13, -16'sd28, 16'sd27, 16'sd1, 16'sd4},
		'{16'sd22, -16'sd8, 16'sd35, -16'sd3, 16'sd14, -16'sd30, 16'sd7, 16'sd19,
			-16'sd21, 16'sd40, 16'sd5, -16'sd12, 16'sd9, 16'sd33, -16'sd6},
		'{-16'sd4, 16'sd51, -16'sd17, 16'sd8, 16'sd29, -16'sd27, -16'sd9, 16'sd44,
			16'sd13, -16'sd2, 16'sd18, 16'sd37, -16'sd24, 16'sd6, 16'sd12},
		'{16'sd31, 16'sd0, -16'sd11, 16'sd25, -16'sd19, -16'sd22, 16'sd55, 16'sd3,
			-16'sd7, 16'sd16, 16'sd42, -16'sd14, 16'sd20, -16'sd26, 16'sd8},
		'{16'sd9, -16'sd23, 16'sd46, 16'sd12, -16'sd5, -16'sd29, 16'sd21, -16'sd16,
			16'sd38, 16'sd27, -16'sd10, 16'sd4, 16'sd58, -16'sd8, 16'sd17},
		'{-16'sd28, 16'sd17, 16'sd6, -16'sd20, 16'sd47, -16'sd18, -16'sd3, 16'sd30,
			16'sd11, -16'sd15, 16'sd24, 16'sd53, -16'sd1, 16'sd19, -16'sd9},
		'{16'sd14, 16'sd36, -16'sd26, 16'sd5, -16'sd12, -16'sd24, 16'sd39, -16'sd5,
			16'sd60, -16'sd19, 16'sd7, -16'sd30, 16'sd15, 16'sd28, 16'sd2},
		'{-16'sd7, -16'sd14, 16'sd23, 16'sd49, 16'sd3, -16'sd21, -16'sd18, 16'sd26,
			-16'sd25, 16'sd8, 16'sd34, 16'sd11, -16'sd6, 16'sd45, -16'sd20}
	};

	localparam hiddenBiases_t HIDDEN_BIASES = '{
		16'sd11, -16'sd5, 16'sd20, 16'sd3, -16'sd12, 16'sd8, 16'sd0, 16'sd15
	};

	localparam outputWeights_t OUTPUT_WEIGHTS = '{
		'{16'sd12, -16'sd20, 16'sd7, 16'sd15, -16'sd9, 16'sd25, -16'sd4, 16'sd3},
		'{-16'sd6, 16'sd18, 16'sd22, -16'sd11, 16'sd14, -16'sd3, 16'sd9, 16'sd27},
		'{16'sd20, 16'sd5, -16'sd15, 16'sd30, -16'sd8, 16'sd11, -16'sd22, 16'sd6},
		'{-16'sd13, 16'sd24, 16'sd4, -16'sd7, 16'sd19, -16'sd17, 16'sd28, -16'sd10}
	};

	// classes 1 and 2 tie when every hidden activation is clamped to zero.
	localparam outputBiases_t OUTPUT_BIASES = '{
		-16'sd20, 16'sd35, 16'sd35, 16'sd10
	};

endpackage

/* design/neuronNode.sv */
`timescale 1ns/1ns

module neuronNode import mlpPkg::*; #(
	parameter int numInputs = NUM_INPUTS,
	parameter weight_t [0:numInputs-1] weights = '0,
	parameter activation_t bias = '0,
	parameter bit reluEnable = 1'b1
) (
	input logic clk,
	input logic reset,
	input activation_t [numInputs-1:0] inputs,
	output activation_t activation
);

	activation_t [numInputs-1:0] inputsReg;
	activation_t [numInputs-1:0] products;
	activation_t weightedSum;
	activation_t sumReg;
	activation_t rectified;

	// a 16 bit context keeps the low half of each product, which is the same
	// for signed and unsigned operands.
	always_comb
	begin
		for (int i = 0; i < numInputs; i++)
		begin
			products[i] = inputsReg[i] * weights[i];
		end
	end

	always_comb
	begin
		weightedSum = bias;
		for (int i = 0; i < numInputs; i++)
		begin
			weightedSum = weightedSum + products[i]; // carries out of bit 15 are lost.
		end
	end

	always_comb
	begin
		if (reluEnable && sumReg[15])
		begin
			rectified = '0; // negative sums are clamped.
		end
		else
		begin
			rectified = sumReg;
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			inputsReg <= '0;
		end
		else
		begin
			inputsReg <= inputs;
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			sumReg <= '0;
			activation <= '0;
		end
		else
		begin
			sumReg <= weightedSum;
			activation <= rectified;
		end
	end

endmodule

/* design/denseLayer.sv */
`timescale 1ns/1ns

module denseLayer import mlpPkg::*; #(
	parameter int numInputs = NUM_INPUTS,
	parameter int numNeurons = NUM_HIDDEN,
	parameter weight_t [0:numNeurons-1][0:numInputs-1] weights = '0,
	parameter activation_t [0:numNeurons-1] biases = '0,
	parameter bit reluEnable = 1'b1
) (
	input logic clk,
	input logic reset,
	input activation_t [numInputs-1:0] inputs,
	input logic inValid,
	output activation_t [numNeurons-1:0] outputs,
	output logic outValid
);

	logic [NEURON_LATENCY-1:0] validPipe;

	for (genvar n = 0; n < numNeurons; n++)
	begin : gNeuron
		neuronNode #(
			.numInputs(numInputs),
			.weights(weights[n]),
			.bias(biases[n]),
			.reluEnable(reluEnable)
		) uNeuron (
			.clk(clk),
			.reset(reset),
			.inputs(inputs),
			.activation(outputs[n])
		);
	end

	// the strobe walks alongside the data through the three neuron stages.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			validPipe <= '0;
		end
		else
		begin
			validPipe <= {validPipe[NEURON_LATENCY-2:0], inValid};
		end
	end

	assign outValid = validPipe[NEURON_LATENCY-1];

endmodule

/* design/classSelector.sv */
`timescale 1ns/1ns

module classSelector import mlpPkg::*; #(
	parameter int numClasses = NUM_CLASSES
) (
	input logic clk,
	input logic reset,
	input activation_t [numClasses-1:0] scores,
	input logic scoresValid,
	output classResult_t result
);

	classIndex_t bestIndex;
	activation_t bestScore;

	// strict comparison so the lowest index survives a tie.
	always_comb
	begin
		bestIndex = '0;
		bestScore = scores[0];
		for (int i = 1; i < numClasses; i++)
		begin
			if ($signed(scores[i]) > $signed(bestScore))
			begin
				bestIndex = classIndex_t'(i);
				bestScore = scores[i];
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			result.valid <= 1'b0;
		end
		else
		begin
			result.valid <= scoresValid;
		end
	end

	// the payload only moves with a valid set of scores, so it reads zero
	// until the first sample has come through.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			result.classIndex <= '0;
			result.score <= '0;
		end
		else if (scoresValid)
		begin
			result.classIndex <= bestIndex;
			result.score <= bestScore;
		end
	end

endmodule

/* design/mlpClassifier.sv */
`timescale 1ns/1ns

module mlpClassifier import mlpPkg::*; #(
	parameter int numInputs = NUM_INPUTS,
	parameter int numHidden = NUM_HIDDEN,
	parameter int numClasses = NUM_CLASSES
) (
	input logic clk,
	input logic reset,
	input sampleBus_t sample,
	output classResult_t result
);

	activation_t [numHidden-1:0] hiddenActivations;
	logic hiddenValid;
	activation_t [numClasses-1:0] classScores;
	logic scoresValid;

	denseLayer #(
		.numInputs(numInputs),
		.numNeurons(numHidden),
		.weights(HIDDEN_WEIGHTS),
		.biases(HIDDEN_BIASES),
		.reluEnable(1'b1)
	) hiddenLayer (
		.clk(clk),
		.reset(reset),
		.inputs(sample.activations),
		.inValid(sample.valid),
		.outputs(hiddenActivations),
		.outValid(hiddenValid)
	);

	// raw scores go to the selector, negative values included.
	denseLayer #(
		.numInputs(numHidden),
		.numNeurons(numClasses),
		.weights(OUTPUT_WEIGHTS),
		.biases(OUTPUT_BIASES),
		.reluEnable(1'b0)
	) outputLayer (
		.clk(clk),
		.reset(reset),
		.inputs(hiddenActivations),
		.inValid(hiddenValid),
		.outputs(classScores),
		.outValid(scoresValid)
	);

	classSelector #(
		.numClasses(numClasses)
	) uClassSelector (
		.clk(clk),
		.reset(reset),
		.scores(classScores),
		.scoresValid(scoresValid),
		.result(result)
	);

endmodule

/* verif/mlpClassifier_properties.sv */
`timescale 1ns/1ns

module mlpClassifierProperties import mlpPkg::*; (
	input logic clk,
	input logic reset,
	input sampleBus_t sample,
	input activation_t [NUM_CLASSES-1:0] scores,
	input classResult_t result
);

	logic [6:0] resetHistory; // reset as seen on the last seven edges.
	activation_t [NUM_CLASSES-1:0] scoresReg; // the scores the selector saw on the last edge.

	always_ff @(posedge clk)
	begin
		resetHistory <= {resetHistory[5:0], reset};
	end

	always_ff @(posedge clk)
	begin
		scoresReg <= scores;
	end

	property clearAfterReset;
		@(posedge clk) reset |=> !result.valid;
	endproperty

	// only once seven clean edges have passed does every stage hold a real sample.
	property fixedLatency;
		@(posedge clk) disable iff (reset)
			resetHistory == '0 |-> result.valid == $past(sample.valid, 7);
	endproperty

	property indexMatchesScore;
		@(posedge clk) disable iff (reset)
			result.valid |-> int'(result.classIndex) < NUM_CLASSES
				&& result.score == scoresReg[result.classIndex];
	endproperty

	aClearAfterReset: assert property (clearAfterReset) else $error("result valid after reset");
	aFixedLatency: assert property (fixedLatency) else $error("result valid out of step");
	aIndexMatchesScore: assert property (indexMatchesScore)
		else $error("class index does not point at the reported score");

endmodule

bind mlpClassifier mlpClassifierProperties uProperties (
	.clk(clk),
	.reset(reset),
	.sample(sample),
	.scores(classScores),
	.result(result)
);

/* verif/mlpClassifierTb.sv */
`timescale 1ns/1ns

module mlpClassifierTb import mlpPkg::*; ();

	localparam int CLK_PERIOD = 100;
	localparam int LATENCY = 7;
	localparam int STREAM_LENGTH = 40;
	localparam int TEST_CYCLES = 2 + 10 + 4 * 30 + 2 * STREAM_LENGTH + 30; // short tests stay under 30.
	localparam int MARGIN_CYCLES = 100;

	typedef activation_t [NUM_INPUTS-1:0] inputVector_t;
	typedef activation_t [NUM_HIDDEN-1:0] hiddenVector_t;

	logic clk;
	logic reset;
	sampleBus_t sample;
	classResult_t result;
	classResult_t expectPipe [LATENCY];
	int errorCount = 0;
	int checkCount = 0;

	mlpClassifier u_dut (.clk(clk), .reset(reset), .sample(sample), .result(result));

	initial clk = 1'b0;
	always #(CLK_PERIOD / 2) clk = ~clk;

	function automatic hiddenVector_t hiddenModel(input inputVector_t acts);
		hiddenVector_t hidden;
		activation_t acc;
		for (int n = 0; n < NUM_HIDDEN; n++)
		begin
			acc = HIDDEN_BIASES[n];
			for (int i = 0; i < NUM_INPUTS; i++)
			begin
				acc = acc + activation_t'(acts[i] * HIDDEN_WEIGHTS[n][i]); // low 16 bits only.
			end
			hidden[n] = acc[15] ? '0 : acc;
		end
		return hidden;
	endfunction

	function automatic classResult_t resultModel(input inputVector_t acts);
		hiddenVector_t hidden;
		activation_t score;
		classResult_t best;
		hidden = hiddenModel(acts);
		best = '0;
		best.valid = 1'b1;
		for (int c = 0; c < NUM_CLASSES; c++)
		begin
			score = OUTPUT_BIASES[c];
			for (int h = 0; h < NUM_HIDDEN; h++)
			begin
				score = score + activation_t'(hidden[h] * OUTPUT_WEIGHTS[c][h]);
			end
			// a later class has to be strictly larger to take over.
			if (c == 0 || $signed(score) > $signed(best.score))
			begin
				best.classIndex = classIndex_t'(c);
				best.score = score;
			end
		end
		return best;
	endfunction

	function automatic inputVector_t randomVector(input int unsigned maxValue);
		inputVector_t acts;
		for (int i = 0; i < NUM_INPUTS; i++)
		begin
			acts[i] = activation_t'($urandom_range(maxValue, 0));
		end
		return acts;
	endfunction

	function automatic int pendingCount();
		int count;
		count = 0;
		foreach (expectPipe[k])
		begin
			count += int'(expectPipe[k].valid);
		end
		return count;
	endfunction

	task automatic reportError(input string message);
		$display("%s", message);
		errorCount++;
	endtask

	// expected results walk through a copy of the pipeline, one slot per clock.
	always @(posedge clk)
	begin
		for (int k = LATENCY - 1; k > 0; k--)
		begin
			expectPipe[k] = reset ? '0 : expectPipe[k-1];
		end
		expectPipe[0] = (reset || !sample.valid) ? '0 : resultModel(sample.activations);
	end

	always @(negedge clk)
	begin : checkResult
		classResult_t expected;
		expected = expectPipe[LATENCY-1];
		if (!reset && expected.valid)
		begin
			checkCount++;
			assert (result.valid) else reportError($sformatf(
				"%0t: no result came out for the sample sent %0d cycles earlier", $time, LATENCY));
			assert (!result.valid || result.classIndex == expected.classIndex) else reportError(
				$sformatf("FAILED at %0t: result.classIndex expected %0d, got %0d", $time,
				expected.classIndex, result.classIndex));
			assert (!result.valid || result.score == expected.score) else reportError(
				$sformatf("FAILED at %0t: result.score expected %0d, got %0d", $time,
				$signed(expected.score), $signed(result.score)));
		end
		else if (!reset)
		begin
			assert (!result.valid) else reportError($sformatf(
				"%0t: a result came out although no sample was sent for it", $time));
		end
	end

	task automatic sendSample(input logic valid, input inputVector_t acts);
		@(negedge clk);
		sample.valid = valid;
		sample.activations = acts;
	endtask

	task automatic drainPipeline();
		int waited;
		waited = 0;
		sendSample(1'b0, '0);
		while (pendingCount() != 0 && waited < 3 * LATENCY)
		begin
			@(negedge clk);
			waited++;
		end
		assert (pendingCount() == 0) else reportError("the pipeline did not empty in time");
	endtask

	task automatic checkHidden(input inputVector_t acts);
		hiddenVector_t expected;
		int waited;
		expected = hiddenModel(acts);
		waited = 0;
		while (!u_dut.hiddenValid && waited < LATENCY)
		begin
			@(negedge clk);
			sample.valid = 1'b0;
			waited++;
		end
		assert (u_dut.hiddenValid) else reportError("the hidden layer never marked its outputs valid");
		for (int n = 0; n < NUM_HIDDEN; n++)
		begin
			assert (u_dut.hiddenActivations[n] == expected[n]) else reportError($sformatf(
				"FAILED at %0t: hiddenActivations[%0d] expected %0d, got %0d", $time, n,
				expected[n], u_dut.hiddenActivations[n]));
		end
	endtask

	task automatic finishTest(input string name, input int errorsBefore);
		$display("%s finished with %0d errors", name, errorCount - errorsBefore);
	endtask

	task automatic testReset();
		int errorsBefore = errorCount;
		repeat (10)
		begin
			sendSample(1'b0, randomVector(16'hFFFF)); // payload without valid is ignored.
			assert (result == '0) else reportError($sformatf(
				"FAILED at %0t: result expected %h, got %h", $time, classResult_t'('0), result));
		end
		finishTest("reset", errorsBefore);
	endtask

	task automatic testZeroSample();
		int errorsBefore = errorCount;
		sendSample(1'b1, '0);
		checkHidden('0); // hidden outputs are just the clamped biases.
		drainPipeline();
		finishTest("zero sample", errorsBefore);
	endtask

	task automatic testDirected();
		int errorsBefore = errorCount;
		inputVector_t acts;
		acts = randomVector(15);
		acts[5] = 16'd400; // input 5 drags the hidden sums negative.
		sendSample(1'b1, acts);
		checkHidden(acts);
		drainPipeline();
		acts = '0;
		acts[5] = 16'd1000; // all hidden clamp, classes 1 and 2 tie on their biases.
		sendSample(1'b1, acts);
		checkHidden(acts);
		drainPipeline();
		finishTest("directed", errorsBefore);
	endtask

	task automatic testWraparound();
		int errorsBefore = errorCount;
		sendSample(1'b1, {NUM_INPUTS{16'hFFFF}});
		sendSample(1'b1, {NUM_INPUTS{16'h7FFF}});
		sendSample(1'b1, {NUM_INPUTS{16'h8000}});
		repeat (4)
		begin
			sendSample(1'b1, randomVector(16'hFFFF));
		end
		drainPipeline();
		finishTest("wraparound", errorsBefore);
	endtask

	task automatic testStream();
		int errorsBefore = errorCount;
		repeat (STREAM_LENGTH)
		begin
			sendSample(1'b1, randomVector(255));
		end
		repeat (STREAM_LENGTH)
		begin
			sendSample(1'($urandom_range(1, 0)), randomVector(16'hFFFF));
		end
		drainPipeline();
		finishTest("stream", errorsBefore);
	endtask

	initial
	begin
		void'($urandom(32'h5a66_0e5d));
		reset = 1'b1;
		sample = '0;
		repeat (2) @(negedge clk);
		reset = 1'b0;
		testReset();
		testZeroSample();
		testDirected();
		testWraparound();
		testStream();
		$display("results checked: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0)
		begin
			$display("test passed");
		end
		else
		begin
			$display("test failed");
		end
		$finish;
	end

	initial
	begin
		#((TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
		$display("watchdog: the run went past %0d cycles", TEST_CYCLES + MARGIN_CYCLES);
		$display("test failed");
		$finish;
	end

endmodule

/* sources.f */
design/mlpPkg.sv
design/neuronNode.sv
design/denseLayer.sv
design/classSelector.sv
design/mlpClassifier.sv
verif/mlpClassifier_properties.sv
verif/mlpClassifierTb.sv

/* Makefile */
TOP = mlpClassifierTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f sources.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP) -o simv
	./obj_dir/simv +verilator+error+limit+100 | tee sim.log
	grep -q "^test passed$$" sim.log

clean:
	rm -rf obj_dir sim.log
